// File: rtl/MipiMonPkg.sv
`default_nettype none

package MipiMonPkg;

	//////////////////////////////////////////////////////////////////////
	// Measurement widths

	typedef logic [15:0] PixCountT;	// Pixels per line or lines per frame
	typedef logic [7:0] FrameCountT;	// Frames in one window
	typedef logic [3:0] PixNumT;	// Pixels delivered per Valid cycle
	typedef logic [1:0] VcIdT;	// CSI-2 virtual channel number
	typedef logic [3:0] VcMaskT;	// One bit per virtual channel
	typedef logic [27:0] TickCountT;	// Window divider, holds 1 s of SysClk

	//////////////////////////////////////////////////////////////////////
	// Timing constants

	// Valid low this long closes a line
	localparam int LineEndHold = 7;

	// Nominal SysClk, also the window length in cycles
	localparam TickCountT DefaultClkFreqHz = 28'd100_000_000;

endpackage

`default_nettype wire

// File: rtl/RxEventIf.sv
`timescale 1ns/10ps
`default_nettype none

// Single-cycle receive events shared by the measurement blocks
interface RxEventIf;

	logic HSyncRise;	// Line start strobe
	logic VSyncRise;	// Frame start strobe
	logic VSyncFall;	// Frame strobe released
	logic ValidRise;	// Start of a pixel burst
	logic LineEnd;	// Valid idle long enough
	logic WinTick;	// End of measurement window

	modport Source
	(
		output HSyncRise,
		output VSyncRise,
		output VSyncFall,
		output ValidRise,
		output LineEnd,
		output WinTick
	);

	modport Sink
	(
		input HSyncRise,
		input VSyncRise,
		input VSyncFall,
		input ValidRise,
		input LineEnd,
		input WinTick
	);

endinterface

`default_nettype wire

// File: rtl/RxEventGen.sv
`timescale 1ns/10ps
`default_nettype none

module RxEventGen
#(
	parameter MipiMonPkg::TickCountT ClkFreqHz = MipiMonPkg::DefaultClkFreqHz	// Cycles per window
)
(
	input logic SysClk,
	input logic Reset_N,
	input logic PixelRxHSync,	// Raw line strobe
	input logic PixelRxVSync,	// Raw frame strobe
	input logic PixelRxValid,	// Raw pixel valid
	RxEventIf.Source Events
);

	import MipiMonPkg::*;

	localparam int HoldW = $clog2(LineEndHold + 1);	// Hold counter width
	localparam TickCountT TickLast = ClkFreqHz - TickCountT'(1);	// Divider reload

	//////////////////////////////////////////////////////////////////////
	// Strobe history and edge pulses

	logic [1:0] HSyncHist;	// Bit 0 newest sample
	logic [1:0] VSyncHist;
	logic [1:0] ValidHist;

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			HSyncHist <= '0;
			VSyncHist <= '0;
			ValidHist <= '0;
			Events.HSyncRise <= 1'b0;
			Events.VSyncRise <= 1'b0;
			Events.VSyncFall <= 1'b0;
			Events.ValidRise <= 1'b0;
		end
		else
		begin
			HSyncHist <= {HSyncHist[0], PixelRxHSync};	// Shift in new sample
			VSyncHist <= {VSyncHist[0], PixelRxVSync};
			ValidHist <= {ValidHist[0], PixelRxValid};
			Events.HSyncRise <= (HSyncHist == 2'b01);	// Low then high
			Events.VSyncRise <= (VSyncHist == 2'b01);
			Events.VSyncFall <= (VSyncHist == 2'b10);	// High then low
			Events.ValidRise <= (ValidHist == 2'b01);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Line end after LineEndHold idle cycles

	logic [HoldW-1:0] HoldCnt;	// Idle cycles left

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			HoldCnt <= '0;
			Events.LineEnd <= 1'b0;
		end
		else
		begin
			if (PixelRxValid)
				HoldCnt <= HoldW'(LineEndHold);	// Each pixel cycle restarts the hold
			else if (HoldCnt != '0)
				HoldCnt <= HoldCnt - HoldW'(1);
			Events.LineEnd <= (HoldCnt == HoldW'(1)) & ~PixelRxValid;	// Fires once per gap
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Window divider

	TickCountT TickCnt;	// Counts down to zero

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			TickCnt <= TickLast;	// First tick ClkFreqHz cycles out
			Events.WinTick <= 1'b0;
		end
		else
		begin
			if (TickCnt == '0)
				TickCnt <= TickLast;
			else
				TickCnt <= TickCnt - TickCountT'(1);
			Events.WinTick <= (TickCnt == '0);	// One pulse per window
		end
	end

endmodule

`default_nettype wire

// File: rtl/FrameGeometry.sv
`timescale 1ns/10ps
`default_nettype none

module FrameGeometry
(
	input logic SysClk,
	input logic Reset_N,
	RxEventIf.Sink Events,
	input logic PixelRxValid,	// Pixel strobe, counted as it arrives
	input MipiMonPkg::PixNumT MipiRxPixNum,	// Pixels in this Valid cycle
	output MipiMonPkg::FrameCountT FrameRate,	// Frames in last window
	output MipiMonPkg::PixCountT VLines,	// Lines in last frame
	output MipiMonPkg::PixCountT HPixels,	// Pixels in last line
	output logic ResChange	// Geometry moved recently
);

	import MipiMonPkg::*;

	FrameCountT FrameCnt;	// VSync rises this window
	PixCountT LineCnt;	// HSync rises this frame
	PixCountT PixCnt;	// Pixels this line
	logic FrameLost;	// Window closed with no frames latched
	logic RateChg;
	logic LinesChg;
	logic PixChg;
	logic [1:0] ChgNote;	// Bit 0 this window, bit 1 last window

	// No frame in the previous window either, drop stale geometry
	assign FrameLost = Events.WinTick & (FrameRate == '0);

	//////////////////////////////////////////////////////////////////////
	// Frame rate per window

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			FrameCnt <= '0;
			FrameRate <= '0;
		end
		else if (Events.WinTick)
		begin
			FrameCnt <= Events.VSyncRise ? FrameCountT'(1) : '0;	// Rise on the boundary counts next
			FrameRate <= FrameCnt;
		end
		else if (Events.VSyncRise)
			FrameCnt <= FrameCnt + FrameCountT'(1);
	end

	//////////////////////////////////////////////////////////////////////
	// Lines per frame

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			LineCnt <= '0;
			VLines <= '0;
		end
		else
		begin
			if (Events.VSyncRise)
				LineCnt <= Events.HSyncRise ? PixCountT'(1) : '0;	// New frame
			else if (Events.HSyncRise)
				LineCnt <= LineCnt + PixCountT'(1);
			if (FrameLost)
				VLines <= '0;
			else if (Events.VSyncRise)
				VLines <= LineCnt;	// Previous frame complete
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pixels per line

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			PixCnt <= '0;
			HPixels <= '0;
		end
		else
		begin
			if (Events.LineEnd)
				PixCnt <= PixelRxValid ? PixCountT'(MipiRxPixNum) : '0;	// Next line may start here
			else if (PixelRxValid)
				PixCnt <= PixCnt + PixCountT'(MipiRxPixNum);
			if (FrameLost)
				HPixels <= '0;
			else if (Events.LineEnd)
				HPixels <= PixCnt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Resolution change, held across one extra window

	assign RateChg = Events.WinTick & (FrameRate != FrameCnt);	// Old vs new latch
	assign LinesChg = Events.VSyncRise & (VLines != LineCnt);
	assign PixChg = Events.LineEnd & (HPixels != PixCnt);

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			ChgNote <= '0;
			ResChange <= 1'b0;
		end
		else
		begin
			if (RateChg | LinesChg | PixChg)
				ChgNote[0] <= 1'b1;	// Setting wins over window clear
			else if (Events.WinTick)
				ChgNote[0] <= 1'b0;
			if (Events.WinTick)
				ChgNote[1] <= ChgNote[0];	// Carry into next window
			ResChange <= |ChgNote;
		end
	end

endmodule

`default_nettype wire

// File: rtl/LinkActivity.sv
`timescale 1ns/10ps
`default_nettype none

module LinkActivity
(
	input logic SysClk,
	input logic Reset_N,
	RxEventIf.Sink Events,
	input MipiMonPkg::VcIdT MipiRxVirtCnl,	// Channel of current burst
	input logic PixelRxReset,	// Receiver reset, drops lane activity
	output MipiMonPkg::VcMaskT VcActive,	// Channels seen last window
	output logic LanesActive,	// Any burst last window
	output logic SyncErr	// Window without HSync or VSync edge
);

	import MipiMonPkg::*;

	VcMaskT VcMask;	// Channels seen so far this window
	VcMaskT VcHit;	// Decoded current channel
	logic HSyncMiss;	// No HSync rise yet
	logic VSyncMiss;	// No VSync edge yet

	assign VcHit = VcMaskT'(1) << MipiRxVirtCnl;

	//////////////////////////////////////////////////////////////////////
	// Virtual channel and lane activity

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			VcMask <= '0;
			VcActive <= '0;
		end
		else if (Events.WinTick)
		begin
			VcMask <= Events.ValidRise ? VcHit : '0;	// Restart collection
			VcActive <= VcMask;
		end
		else if (Events.ValidRise)
			VcMask <= VcMask | VcHit;
	end

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
			LanesActive <= 1'b0;
		else if (PixelRxReset)
			LanesActive <= 1'b0;	// Lanes down until next window proves otherwise
		else if (Events.WinTick)
			LanesActive <= |VcMask;
	end

	//////////////////////////////////////////////////////////////////////
	// Sync error check

	always_ff @(posedge SysClk or negedge Reset_N)
	begin
		if (!Reset_N)
		begin
			HSyncMiss <= 1'b0;	// Armed by first WinTick
			VSyncMiss <= 1'b0;
			SyncErr <= 1'b0;
		end
		else
		begin
			if (Events.WinTick)
				HSyncMiss <= 1'b1;
			else if (Events.HSyncRise)
				HSyncMiss <= 1'b0;
			if (Events.WinTick)
				VSyncMiss <= 1'b1;
			else if (Events.VSyncRise | Events.VSyncFall)
				VSyncMiss <= 1'b0;	// Either VSync edge will do
			SyncErr <= Events.WinTick & (HSyncMiss | VSyncMiss);	// Single cycle pulse
		end
	end

endmodule

`default_nettype wire

// File: rtl/MipiRxMonitor.sv
`timescale 1ns/10ps
`default_nettype none

module MipiRxMonitor
#(
	parameter MipiMonPkg::TickCountT ClkFreqHz = MipiMonPkg::DefaultClkFreqHz	// SysClk in Hz
)
(
	input logic SysClk,
	input logic Reset_N,
	// Pixel side of the CSI-2 receiver
	input logic PixelRxReset,	// DPHY or CSI reset active
	input logic PixelRxHSync,
	input logic PixelRxVSync,
	input logic PixelRxValid,
	input MipiMonPkg::PixNumT MipiRxPixNum,
	input MipiMonPkg::VcIdT MipiRxVirtCnl,
	// Measurements, refreshed each window
	output MipiMonPkg::FrameCountT FrameRate,
	output MipiMonPkg::PixCountT VLines,
	output MipiMonPkg::PixCountT HPixels,
	output logic ResChange,
	output MipiMonPkg::VcMaskT VcActive,
	output logic LanesActive,
	output logic SyncErr
);

	//////////////////////////////////////////////////////////////////////
	// Event generation

	RxEventIf Events();	// Shared pulses, one driver

	RxEventGen #(
		.ClkFreqHz(ClkFreqHz)
	) uEventGen (
		.SysClk(SysClk),
		.Reset_N(Reset_N),
		.PixelRxHSync(PixelRxHSync),
		.PixelRxVSync(PixelRxVSync),
		.PixelRxValid(PixelRxValid),
		.Events(Events.Source)
	);

	//////////////////////////////////////////////////////////////////////
	// Measurement blocks

	FrameGeometry uGeometry (
		.SysClk(SysClk),
		.Reset_N(Reset_N),
		.Events(Events.Sink),
		.PixelRxValid(PixelRxValid),	// Raw, for same-cycle pixel sum
		.MipiRxPixNum(MipiRxPixNum),
		.FrameRate(FrameRate),
		.VLines(VLines),
		.HPixels(HPixels),
		.ResChange(ResChange)
	);

	LinkActivity uActivity (
		.SysClk(SysClk),
		.Reset_N(Reset_N),
		.Events(Events.Sink),
		.MipiRxVirtCnl(MipiRxVirtCnl),
		.PixelRxReset(PixelRxReset),
		.VcActive(VcActive),
		.LanesActive(LanesActive),
		.SyncErr(SyncErr)
	);

endmodule

`default_nettype wire

// File: tb/MipiRxMonitor_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module MipiRxMonitor_assertions
(
	input logic SysClk,
	input logic Reset_N,
	input logic PixelRxReset,
	input MipiMonPkg::FrameCountT FrameRate,
	input MipiMonPkg::PixCountT VLines,
	input MipiMonPkg::PixCountT HPixels,
	input logic ResChange,
	input MipiMonPkg::VcMaskT VcActive,
	input logic LanesActive,
	input logic SyncErr
);

	int AssertErrs = 0;	// Failed assertion count

	//////////////////////////////////////////////////////////////////////
	// Output protocol

	SyncErrSingle: assert property (@(posedge SysClk) disable iff (!Reset_N)
		SyncErr |=> !SyncErr)
		else
		begin
			$error("SyncErr high for two cycles in a row");	// Must be a pulse
			AssertErrs = AssertErrs + 1;
		end

	OutputsZeroInReset: assert property (@(posedge SysClk)
		!Reset_N |-> (FrameRate == '0 && VLines == '0 && HPixels == '0 &&
			!ResChange && VcActive == '0 && !LanesActive && !SyncErr))
		else
		begin
			$error("Outputs not cleared while Reset_N low");
			AssertErrs = AssertErrs + 1;
		end

	LanesDropOnRxReset: assert property (@(posedge SysClk) disable iff (!Reset_N)
		PixelRxReset |=> !LanesActive)
		else
		begin
			$error("LanesActive still high after PixelRxReset");	// Receiver reset drops lanes
			AssertErrs = AssertErrs + 1;
		end

endmodule

bind MipiRxMonitor MipiRxMonitor_assertions uAssertions
(
	.SysClk(SysClk),
	.Reset_N(Reset_N),
	.PixelRxReset(PixelRxReset),
	.FrameRate(FrameRate),
	.VLines(VLines),
	.HPixels(HPixels),
	.ResChange(ResChange),
	.VcActive(VcActive),
	.LanesActive(LanesActive),
	.SyncErr(SyncErr)
);

`default_nettype wire

// File: tb/MipiRxMonitorTb.sv
`timescale 1ns/10ps
`default_nettype none

module MipiRxMonitorTb;

	import MipiMonPkg::*;

	localparam int WinLen = 2000;	// Cycles per window, matches ClkFreqHz
	localparam int NumWin = 14;
	localparam int MaxPix = 6;	// Longest Valid burst
	localparam int TimeoutLimit = 40000;	// 14 windows plus margin

	logic SysClk = 1'b0;
	logic Reset_N;
	logic PixelRxReset;
	logic PixelRxHSync;
	logic PixelRxVSync;
	logic PixelRxValid;
	PixNumT MipiRxPixNum;
	VcIdT MipiRxVirtCnl;
	FrameCountT FrameRate;
	PixCountT VLines;
	PixCountT HPixels;
	logic ResChange;
	VcMaskT VcActive;
	logic LanesActive;
	logic SyncErr;

	integer Seed;	// Random state
	int Cyc;	// Cycles since reset release
	int ValueErrs = 0;
	int AssertErrs = 0;	// Copied from the bound checker at the end
	int CheckCount = 0;
	int TimeoutCnt = 0;
	int SyncErrCnt = 0;	// SyncErr pulses seen so far
	int ResChgCnt = 0;	// Cycles with ResChange high
	int SyncErrMark;
	int ResChgMark;

	// Per window stimulus plan
	int WinFrames[NumWin];
	int WinLines[NumWin];
	int LinePixLen[NumWin];
	PixNumT LinePix[NumWin][MaxPix];
	VcMaskT WinMask[NumWin];	// Filled while sending

	// Model of the latched results
	FrameCountT ExpRate;
	PixCountT ExpV;
	PixCountT ExpH;

	MipiRxMonitor #(
		.ClkFreqHz(28'd2000)
	) u_dut (
		.SysClk(SysClk),
		.Reset_N(Reset_N),
		.PixelRxReset(PixelRxReset),
		.PixelRxHSync(PixelRxHSync),
		.PixelRxVSync(PixelRxVSync),
		.PixelRxValid(PixelRxValid),
		.MipiRxPixNum(MipiRxPixNum),
		.MipiRxVirtCnl(MipiRxVirtCnl),
		.FrameRate(FrameRate),
		.VLines(VLines),
		.HPixels(HPixels),
		.ResChange(ResChange),
		.VcActive(VcActive),
		.LanesActive(LanesActive),
		.SyncErr(SyncErr)
	);

	always #50 SysClk = ~SysClk;	// 100 ns period

	//////////////////////////////////////////////////////////////////////
	// Watchers and timeout

	always @(negedge SysClk)
	begin
		if (SyncErr === 1'b1)
			SyncErrCnt <= SyncErrCnt + 1;
		if (ResChange === 1'b1)
			ResChgCnt <= ResChgCnt + 1;
	end

	always @(posedge SysClk)
	begin
		TimeoutCnt <= TimeoutCnt + 1;
		if (TimeoutCnt >= TimeoutLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", TimeoutLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic CheckFrameCount(input string Name, input FrameCountT Exp, input FrameCountT Act);
		CheckCount++;
		if (Exp !== Act)
		begin
			ValueErrs++;
			$display("ERR %s: expected %0d, actual %0d", Name, Exp, Act);
		end
	endtask

	task automatic CheckPixCount(input string Name, input PixCountT Exp, input PixCountT Act);
		CheckCount++;
		if (Exp !== Act)
		begin
			ValueErrs++;
			$display("ERR %s: expected %0d, actual %0d", Name, Exp, Act);
		end
	endtask

	task automatic CheckVcMask(input string Name, input VcMaskT Exp, input VcMaskT Act);
		CheckCount++;
		if (Exp !== Act)
		begin
			ValueErrs++;
			$display("ERR %s: expected %b, actual %b", Name, Exp, Act);
		end
	endtask

	task automatic CheckFlag(input string Name, input logic Exp, input logic Act);
		CheckCount++;
		if (Exp !== Act)
		begin
			ValueErrs++;
			$display("ERR %s: expected %b, actual %b", Name, Exp, Act);
		end
	endtask

	task automatic CheckAllZero(input string Tag);
		CheckFrameCount({Tag, " FrameRate"}, '0, FrameRate);
		CheckPixCount({Tag, " VLines"}, '0, VLines);
		CheckPixCount({Tag, " HPixels"}, '0, HPixels);
		CheckFlag({Tag, " ResChange"}, 1'b0, ResChange);
		CheckVcMask({Tag, " VcActive"}, '0, VcActive);
		CheckFlag({Tag, " LanesActive"}, 1'b0, LanesActive);
		CheckFlag({Tag, " SyncErr"}, 1'b0, SyncErr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic StepCycle();
		@(posedge SysClk);
		#1;	// Drive after the edge
		Cyc++;
	endtask

	task automatic WaitUntil(input int Target);
		while (Cyc < Target)
			StepCycle();
	endtask

	function automatic int RandRange(input int Lo, input int Span);
		RandRange = Lo + int'($unsigned($random(Seed)) % Span);
	endfunction

	task automatic MakeConfig(input int W);
		WinFrames[W] = RandRange(2, 4);	// At least two frames so VLines latches
		WinLines[W] = RandRange(2, 5);
		LinePixLen[W] = RandRange(2, 5);
		for (int I = 0; I < MaxPix; I++)
			LinePix[W][I] = PixNumT'(RandRange(1, 15));
	endtask

	task automatic CopyConfig(input int Dst, input int Src);
		WinFrames[Dst] = WinFrames[Src];
		WinLines[Dst] = WinLines[Src];
		LinePixLen[Dst] = LinePixLen[Src];
		for (int I = 0; I < MaxPix; I++)
			LinePix[Dst][I] = LinePix[Src][I];
	endtask

	task automatic DriveLine(input int W);
		VcIdT Ch;
		Ch = VcIdT'(RandRange(0, 4));
		PixelRxHSync = 1'b1;	// Line start
		repeat (2) StepCycle();
		PixelRxHSync = 1'b0;
		repeat (2) StepCycle();
		MipiRxVirtCnl = Ch;	// Held until next burst
		WinMask[W] = WinMask[W] | (VcMaskT'(1) << Ch);
		for (int I = 0; I < LinePixLen[W]; I++)
		begin
			PixelRxValid = 1'b1;
			MipiRxPixNum = LinePix[W][I];
			StepCycle();
		end
		PixelRxValid = 1'b0;
		MipiRxPixNum = '0;
		repeat (12) StepCycle();	// Longer than LineEndHold
	endtask

	task automatic GenFrame(input int W);
		PixelRxVSync = 1'b1;
		repeat (4) StepCycle();
		PixelRxVSync = 1'b0;
		repeat (2) StepCycle();
		repeat (WinLines[W]) DriveLine(W);
	endtask

	task automatic RunWindow(input int W);
		WaitUntil(W * WinLen + 20);	// Keep clear of the boundary
		repeat (WinFrames[W]) GenFrame(W);
		if (W == 8)
		begin
			WaitUntil(W * WinLen + 1900);
			PixelRxReset = 1'b1;	// Receiver reset late in the window
			StepCycle();
			PixelRxReset = 1'b0;
			repeat (3) StepCycle();
			CheckFlag("W8 LanesAfterRxReset", 1'b0, LanesActive);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic PixCountT LineSum(input int W);
		PixCountT Sum;
		Sum = '0;
		for (int I = 0; I < LinePixLen[W]; I++)
			Sum = Sum + PixCountT'(LinePix[W][I]);
		return Sum;
	endfunction

	task automatic CheckWindow(input int W);
		logic Lost;
		string Tag;
		Tag = $sformatf("W%0d", W);
		Lost = (ExpRate == '0);	// Previous window had no frames
		if (WinFrames[W] >= 2)
		begin
			ExpV = PixCountT'(WinLines[W]);
			ExpH = LineSum(W);
		end
		if (Lost)
		begin
			ExpV = '0;	// Geometry dropped at the window end
			ExpH = '0;
		end
		ExpRate = FrameCountT'(WinFrames[W]);
		CheckFrameCount({Tag, " FrameRate"}, ExpRate, FrameRate);
		CheckPixCount({Tag, " VLines"}, ExpV, VLines);
		CheckPixCount({Tag, " HPixels"}, ExpH, HPixels);
		CheckVcMask({Tag, " VcActive"}, WinMask[W], VcActive);
		CheckFlag({Tag, " LanesActive"}, |WinMask[W], LanesActive);
		CheckFlag({Tag, " SyncErr"}, logic'(W > 0 && WinFrames[W] == 0),
			logic'(SyncErrCnt != SyncErrMark));
		SyncErrMark = SyncErrCnt;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		Seed = 32'hcb74;
		Reset_N = 1'b1;
		PixelRxReset = 1'b0;
		PixelRxHSync = 1'b0;
		PixelRxVSync = 1'b0;
		PixelRxValid = 1'b0;
		MipiRxPixNum = '0;
		MipiRxVirtCnl = '0;
		ExpRate = '0;
		ExpV = '0;
		ExpH = '0;
		SyncErrMark = 0;
		ResChgMark = 0;
		Cyc = 0;
		for (int W = 0; W < NumWin; W++)
		begin
			WinFrames[W] = 0;	// Idle unless set below
			WinLines[W] = 0;
			LinePixLen[W] = 0;
			WinMask[W] = '0;
			for (int I = 0; I < MaxPix; I++)
				LinePix[W][I] = '0;
		end
		MakeConfig(1);
		for (int W = 2; W <= 4; W++)
			CopyConfig(W, 1);
		MakeConfig(5);
		WinLines[5] = WinLines[1] % 6 + 2;	// Always a new line count
		CopyConfig(6, 5);
		CopyConfig(7, 5);
		MakeConfig(8);
		CopyConfig(9, 8);
		MakeConfig(12);
		CopyConfig(13, 12);

		#1 Reset_N = 1'b0;
		repeat (3) @(posedge SysClk);
		#1 Reset_N = 1'b1;
		Cyc = 0;

		for (int W = 0; W < NumWin; W++)
		begin
			WaitUntil(W * WinLen + 10);	// Previous window latched by now
			if (W > 0)
				CheckWindow(W - 1);
			if (W == 0)
				CheckAllZero("Reset");
			if (W == 5)
			begin
				CheckFlag("W5 ResChangeSteady", 1'b0, ResChange);
				ResChgMark = ResChgCnt;
			end
			if (W == 7)
				CheckFlag("W7 ResChangeSeen", 1'b1, logic'(ResChgCnt != ResChgMark));
			RunWindow(W);
			if (W == 0)
			begin
				WaitUntil(1990);
				CheckAllZero("FirstWindow");
			end
		end
		WaitUntil(NumWin * WinLen + 10);
		CheckWindow(NumWin - 1);

		AssertErrs = u_dut.uAssertions.AssertErrs;
		$display("Checks run: %0d, value errors: %0d, assertion errors: %0d",
			CheckCount, ValueErrs, AssertErrs);
		if (ValueErrs == 0 && AssertErrs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/MipiMonPkg.sv
rtl/RxEventIf.sv
rtl/RxEventGen.sv
rtl/FrameGeometry.sv
rtl/LinkActivity.sv
rtl/MipiRxMonitor.sv
tb/MipiRxMonitor_assertions.sv
tb/MipiRxMonitorTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MIPI monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module MipiRxMonitorTb \
	--Mdir obj_dir -o MipiRxMonitorTb > build.log 2>&1 \
	&& ./obj_dir/MipiRxMonitorTb > sim.log 2>&1 \
	&& grep -q "^STATUS: PASS$" sim.log \
	&& echo "Simulation passed" \
	|| { cat build.log sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
